/* source/RenameTypes.sv */
//********************
// Rename front end shared types
// Opcodes, micro-op, renamed-op and commit records plus default sizes
//********************

`default_nettype none

package RenameTypes;

    // Default sizes
    localparam int LOG_REGS = 16;
    localparam int PHYS_REGS_DEFAULT = 32;
    localparam int AL_DEPTH_DEFAULT = 8;

    localparam int PHY_REG_W = $clog2(PHYS_REGS_DEFAULT);
    localparam int AL_PTR_W = $clog2(AL_DEPTH_DEFAULT);

    typedef logic [3:0] LogReg;
    typedef logic [15:0] InstWord;
    typedef logic [PHY_REG_W-1:0] PhyReg;
    typedef logic [AL_PTR_W-1:0] AlPtr;

    // Bits 15..12 of the instruction word
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_LOAD   = 4'd2,
        OP_STORE  = 4'd3,
        OP_BRANCH = 4'd4,
        OP_FENCE  = 4'd5
    } Opcode;

    typedef struct packed {
        Opcode opcode;
        LogReg dst;
        LogReg srcA;
        LogReg srcB;
        logic  writeReg;
        logic  readA;
        logic  readB;
        logic  serialized;
        logic  undefined;
    } OpInfo;

    // Unused sources read as zero
    typedef struct packed {
        OpInfo info;
        PhyReg phySrcA;
        PhyReg phySrcB;
        PhyReg phyDst;
        PhyReg phyPrevDst;
        AlPtr  alPtr;
    } RenamedOp;

    typedef struct packed {
        LogReg dst;
        PhyReg phyDst;
        PhyReg phyPrevDst;
        logic  writeReg;
    } CommitInfo;

endpackage

`default_nettype wire

/* source/OpDecoder.sv */
//********************
// Instruction decoder
// Four-phase instruction port, holds one decoded micro-op
//********************

`default_nettype none

module OpDecoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                instReq,
    input  RenameTypes::InstWord instWord,
    output logic                instAck,
    input  logic                take,
    output RenameTypes::OpInfo  decodedOp,
    output logic                decodedValid
);
    import RenameTypes::*;

    OpInfo nextOp;
    logic  regFree;
    logic  accept;

    // Opcode to flags
    always_comb begin
        nextOp = '0;
        nextOp.dst = instWord[11:8];
        nextOp.srcA = instWord[7:4];
        nextOp.srcB = instWord[3:0];
        case (instWord[15:12])
            OP_NOP, OP_ADD, OP_LOAD, OP_STORE, OP_BRANCH, OP_FENCE: begin
                nextOp.opcode = Opcode'(instWord[15:12]);
            end
            default: begin
                // Treated as a NOP downstream
                nextOp.opcode = OP_NOP;
                nextOp.undefined = 1'b1;
            end
        endcase
        nextOp.writeReg = nextOp.opcode inside {OP_ADD, OP_LOAD};
        nextOp.readA = !(nextOp.opcode inside {OP_NOP, OP_FENCE});
        nextOp.readB = nextOp.opcode inside {OP_ADD, OP_STORE, OP_BRANCH};
        nextOp.serialized = nextOp.opcode == OP_FENCE;
    end

    // Register can refill on the same edge the rename stage takes it
    assign regFree = !decodedValid || take;
    assign accept = instReq && !instAck && regFree;

    always_ff @(posedge clk) begin
        if (rst) begin
            instAck <= 1'b0;
            decodedValid <= 1'b0;
        end else if (accept) begin
            instAck <= 1'b1;
            decodedValid <= 1'b1;
        end else begin
            if (take) begin
                decodedValid <= 1'b0;
            end
            if (!instReq) begin
                instAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decodedOp <= nextOp;
        end
    end

    // Source must hold its request until acknowledged
    assert property (@(posedge clk) disable iff (rst) instReq && !instAck |=> instReq)
        else $error("instReq dropped before instAck was raised");

endmodule

`default_nettype wire

/* source/RenameSerializer.sv */
//********************
// Fence serializer
// Holds a fence until older ops commit, then younger ops until it commits
//********************

`default_nettype none

module RenameSerializer (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  RenameTypes::OpInfo op,
    input  logic               valid,
    input  logic               activeListEmpty,
    output logic               serialize
);
    import RenameTypes::*;

    typedef enum logic {
        PHASE_NORMAL,
        PHASE_WAIT_OWN
    } Phase;

    Phase phase;
    Phase nextPhase;

    always_comb begin
        serialize = 1'b0;
        nextPhase = PHASE_NORMAL;
        if (phase == PHASE_NORMAL) begin
            if (valid && op.serialized) begin
                if (!activeListEmpty) begin
                    // Older ops still in flight
                    serialize = 1'b1;
                end else begin
                    nextPhase = PHASE_WAIT_OWN;
                end
            end
        end else if (!activeListEmpty) begin
            // Fence itself not yet committed
            serialize = 1'b1;
            nextPhase = PHASE_WAIT_OWN;
        end else if (valid && op.serialized) begin
            // Back-to-back fence waits for its own commit
            nextPhase = PHASE_WAIT_OWN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PHASE_NORMAL;
        end else if (!stall) begin
            phase <= nextPhase;
        end
    end

endmodule

`default_nettype wire

/* source/RenameStage.sv */
//********************
// Rename stage
// Pipeline register, stall control and renamed-op assembly
//********************

`default_nettype none

module RenameStage #(
    parameter int PHYS_REGS = RenameTypes::PHYS_REGS_DEFAULT,
    parameter int AL_DEPTH  = RenameTypes::AL_DEPTH_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  RenameTypes::OpInfo           decodedOp,
    input  logic                         decodedValid,
    output logic                         take,
    input  logic [$clog2(PHYS_REGS)-1:0] phySrcA,
    input  logic [$clog2(PHYS_REGS)-1:0] phySrcB,
    input  logic [$clog2(PHYS_REGS)-1:0] phyDst,
    input  logic [$clog2(PHYS_REGS)-1:0] phyPrevDst,
    input  logic                         freeEmpty,
    input  logic [$clog2(AL_DEPTH)-1:0]  alPtr,
    input  logic [$clog2(AL_DEPTH):0]    alCount,
    output logic                         allocate,
    output RenameTypes::RenamedOp        renamed,
    output logic                         renamedValid
);
    import RenameTypes::*;

    OpInfo regOp;
    logic  regValid;
    logic  alFull;
    logic  alEmpty;
    logic  resourceStall;
    logic  serialize;
    logic  stall;

    assign alFull = alCount == ($clog2(AL_DEPTH) + 1)'(AL_DEPTH);
    assign alEmpty = alCount == '0;

    // Resource stall alone advances the serializer phase
    assign resourceStall = regValid && (freeEmpty || alFull);
    assign stall = regValid && (freeEmpty || alFull || serialize);

    assign allocate = regValid && !stall;
    assign renamedValid = allocate;
    assign take = decodedValid && (!regValid || !stall);

    RenameSerializer i_serializer (
        .clk             (clk),
        .rst             (rst),
        .stall           (resourceStall),
        .op              (regOp),
        .valid           (regValid),
        .activeListEmpty (alEmpty),
        .serialize       (serialize)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            regValid <= 1'b0;
        end else if (take) begin
            regValid <= 1'b1;
        end else if (allocate) begin
            regValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            regOp <= decodedOp;
        end
    end

    // NOP and undefined ops carry writeReg low, so no physical register
    always_comb begin
        renamed.info = regOp;
        renamed.phySrcA = regOp.readA ? phySrcA : '0;
        renamed.phySrcB = regOp.readB ? phySrcB : '0;
        renamed.phyDst = regOp.writeReg ? phyDst : '0;
        renamed.phyPrevDst = phyPrevDst;
        renamed.alPtr = alPtr;
    end

endmodule

`default_nettype wire

/* source/RenameMapTable.sv */
//********************
// Register map table and free list
// Logical-to-physical map with a circular FIFO of free registers
//********************

`default_nettype none

module RenameMapTable #(
    parameter int PHYS_REGS = RenameTypes::PHYS_REGS_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  RenameTypes::LogReg           srcA,
    input  RenameTypes::LogReg           srcB,
    input  RenameTypes::LogReg           dst,
    input  logic                         writeReg,
    input  logic                         allocate,
    input  logic                         releaseEn,
    input  logic [$clog2(PHYS_REGS)-1:0] releaseReg,
    output logic [$clog2(PHYS_REGS)-1:0] phySrcA,
    output logic [$clog2(PHYS_REGS)-1:0] phySrcB,
    output logic [$clog2(PHYS_REGS)-1:0] phyDst,
    output logic [$clog2(PHYS_REGS)-1:0] phyPrevDst,
    output logic                         freeEmpty
);
    import RenameTypes::*;

    localparam int PHY_W = $clog2(PHYS_REGS);
    localparam int FREE_REGS = PHYS_REGS - LOG_REGS;
    localparam int FREE_PTR_W = (FREE_REGS > 1) ? $clog2(FREE_REGS) : 1;
    localparam int FREE_CNT_W = $clog2(FREE_REGS + 1);

    logic [PHY_W-1:0]      mapTable [LOG_REGS];
    logic [PHY_W-1:0]      freeList [FREE_REGS];
    logic [FREE_PTR_W-1:0] freeHead;
    logic [FREE_PTR_W-1:0] freeTail;
    logic [FREE_CNT_W-1:0] freeCount;
    logic                  pop;

    assign pop = allocate && writeReg;

    // Lookups for the op sitting in the rename register
    assign phySrcA = mapTable[srcA];
    assign phySrcB = mapTable[srcB];
    assign phyPrevDst = mapTable[dst];
    assign phyDst = freeList[freeHead];
    assign freeEmpty = freeCount == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, spare registers queued in ascending order
            for (int i = 0; i < LOG_REGS; i++) begin
                mapTable[i] <= PHY_W'(i);
            end
            for (int i = 0; i < FREE_REGS; i++) begin
                freeList[i] <= PHY_W'(LOG_REGS + i);
            end
            freeHead <= '0;
            freeTail <= '0;
            freeCount <= FREE_CNT_W'(FREE_REGS);
        end else begin
            if (pop) begin
                mapTable[dst] <= freeList[freeHead];
                freeHead <= (freeHead == FREE_PTR_W'(FREE_REGS - 1)) ? '0 : freeHead + 1'b1;
            end
            if (releaseEn) begin
                freeList[freeTail] <= releaseReg;
                freeTail <= (freeTail == FREE_PTR_W'(FREE_REGS - 1)) ? '0 : freeTail + 1'b1;
            end
            freeCount <= freeCount + FREE_CNT_W'(releaseEn) - FREE_CNT_W'(pop);
        end
    end

    // A commit may only free a register that rename took from here
    assert property (@(posedge clk) disable iff (rst)
        releaseEn && !pop |-> freeCount != FREE_CNT_W'(FREE_REGS))
        else $error("Free list overflow on release of %0d", releaseReg);

endmodule

`default_nettype wire

/* source/ActiveList.sv */
//********************
// Active list
// In-order record of renamed ops, retired by the commit handshake
//********************

`default_nettype none

module ActiveList #(
    parameter int PHYS_REGS = RenameTypes::PHYS_REGS_DEFAULT,
    parameter int AL_DEPTH  = RenameTypes::AL_DEPTH_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         allocate,
    input  RenameTypes::CommitInfo       entry,
    output logic [$clog2(AL_DEPTH)-1:0]  alPtr,
    output logic [$clog2(AL_DEPTH):0]    alCount,
    input  logic                         commitReq,
    output logic                         commitAck,
    output RenameTypes::CommitInfo       committed,
    output logic                         releaseEn,
    output logic [$clog2(PHYS_REGS)-1:0] releaseReg
);
    import RenameTypes::*;

    localparam int AL_W = $clog2(AL_DEPTH);

    CommitInfo       entries [AL_DEPTH];
    logic [AL_W-1:0] head;
    logic [AL_W-1:0] tail;
    logic [AL_W:0]   count;
    logic            retire;

    assign alPtr = tail;
    assign alCount = count;

    // Retire on the edge that raises commitAck
    assign retire = commitReq && !commitAck && (count != '0);
    assign releaseEn = retire && entries[head].writeReg;
    assign releaseReg = entries[head].phyPrevDst;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            commitAck <= 1'b0;
        end else begin
            if (allocate) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
                commitAck <= 1'b1;
            end else if (!commitReq) begin
                commitAck <= 1'b0;
            end
            count <= count + (AL_W + 1)'(allocate) - (AL_W + 1)'(retire);
        end
    end

    // Entry storage and the presented commit record
    always_ff @(posedge clk) begin
        if (allocate) begin
            entries[tail] <= entry;
        end
        if (retire) begin
            committed <= entries[head];
        end
    end

    // Rename must stall before the list fills
    assert property (@(posedge clk) disable iff (rst) allocate |-> count != (AL_W + 1)'(AL_DEPTH))
        else $error("Allocate while the active list is full");

endmodule

`default_nettype wire

/* source/RenameCore.sv */
//********************
// Rename front end top level
//********************

`default_nettype none

module RenameCore #(
    parameter int PHYS_REGS = RenameTypes::PHYS_REGS_DEFAULT,
    parameter int AL_DEPTH  = RenameTypes::AL_DEPTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReq,
    input  RenameTypes::InstWord   instWord,
    output logic                   instAck,
    output RenameTypes::RenamedOp  renamed,
    output logic                   renamedValid,
    input  logic                   commitReq,
    output logic                   commitAck,
    output RenameTypes::CommitInfo committed
);
    import RenameTypes::*;

    localparam int PHY_W = $clog2(PHYS_REGS);
    localparam int AL_W = $clog2(AL_DEPTH);

    // Struct layout is fixed by the package defaults
    if (PHYS_REGS <= LOG_REGS || PHY_W != $bits(PhyReg)) begin : gPhysCheck
        $error("PHYS_REGS does not match the renamed-op layout");
    end
    if ((AL_DEPTH & (AL_DEPTH - 1)) != 0 || AL_W != $bits(AlPtr)) begin : gAlCheck
        $error("AL_DEPTH must be a power of two matching the renamed-op layout");
    end

    OpInfo            decodedOp;
    logic             decodedValid;
    logic             take;
    logic             allocate;
    logic [PHY_W-1:0] phySrcA;
    logic [PHY_W-1:0] phySrcB;
    logic [PHY_W-1:0] phyDst;
    logic [PHY_W-1:0] phyPrevDst;
    logic             freeEmpty;
    logic [AL_W-1:0]  alPtr;
    logic [AL_W:0]    alCount;
    logic             releaseEn;
    logic [PHY_W-1:0] releaseReg;
    CommitInfo        alEntry;

    assign alEntry = '{
        dst:        renamed.info.dst,
        phyDst:     renamed.phyDst,
        phyPrevDst: renamed.phyPrevDst,
        writeReg:   renamed.info.writeReg
    };

    OpDecoder i_decoder (
        .clk          (clk),
        .rst          (rst),
        .instReq      (instReq),
        .instWord     (instWord),
        .instAck      (instAck),
        .take         (take),
        .decodedOp    (decodedOp),
        .decodedValid (decodedValid)
    );

    RenameStage #(
        .PHYS_REGS (PHYS_REGS),
        .AL_DEPTH  (AL_DEPTH)
    ) i_renameStage (
        .clk          (clk),
        .rst          (rst),
        .decodedOp    (decodedOp),
        .decodedValid (decodedValid),
        .take         (take),
        .phySrcA      (phySrcA),
        .phySrcB      (phySrcB),
        .phyDst       (phyDst),
        .phyPrevDst   (phyPrevDst),
        .freeEmpty    (freeEmpty),
        .alPtr        (alPtr),
        .alCount      (alCount),
        .allocate     (allocate),
        .renamed      (renamed),
        .renamedValid (renamedValid)
    );

    RenameMapTable #(
        .PHYS_REGS (PHYS_REGS)
    ) i_mapTable (
        .clk        (clk),
        .rst        (rst),
        .srcA       (renamed.info.srcA),
        .srcB       (renamed.info.srcB),
        .dst        (renamed.info.dst),
        .writeReg   (renamed.info.writeReg),
        .allocate   (allocate),
        .releaseEn  (releaseEn),
        .releaseReg (releaseReg),
        .phySrcA    (phySrcA),
        .phySrcB    (phySrcB),
        .phyDst     (phyDst),
        .phyPrevDst (phyPrevDst),
        .freeEmpty  (freeEmpty)
    );

    ActiveList #(
        .PHYS_REGS (PHYS_REGS),
        .AL_DEPTH  (AL_DEPTH)
    ) i_activeList (
        .clk        (clk),
        .rst        (rst),
        .allocate   (allocate),
        .entry      (alEntry),
        .alPtr      (alPtr),
        .alCount    (alCount),
        .commitReq  (commitReq),
        .commitAck  (commitAck),
        .committed  (committed),
        .releaseEn  (releaseEn),
        .releaseReg (releaseReg)
    );

endmodule

`default_nettype wire

/* verification/RenameCoreTb.sv */
//********************
// Rename front end testbench
// Drives both handshakes from the test file and checks every output
//********************

`default_nettype none

module RenameCoreTb;
    import RenameTypes::*;

    // Four spare registers so the free list runs dry before the active list fills
    localparam int TEST_PHYS_REGS = 20;
    localparam int TEST_AL_DEPTH = 8;
    localparam int DRIVE_DELAY = 10;
    localparam int CYCLES_PER_LINE = 40;
    localparam string TEST_FILE = "verification/renameTests.txt";

    logic      clk;
    logic      rst;
    logic      instReq;
    InstWord   instWord;
    logic      instAck;
    RenamedOp  renamed;
    logic      renamedValid;
    logic      commitReq;
    logic      commitAck;
    CommitInfo committed;

    // Expected renamed ops in program order, with the commit count each one waits for
    RenamedOp expRenamed [$];
    int       expCommitsBefore [$];
    RenamedOp nextExp;
    int       nextCount;
    int       commitsSeen;
    int       commitsIssued;
    logic     prevCommitAck;
    int       cycleCount = 0;
    int       cycleLimit = 0;

    RenameCore #(
        .PHYS_REGS (TEST_PHYS_REGS),
        .AL_DEPTH  (TEST_AL_DEPTH)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .instReq      (instReq),
        .instWord     (instWord),
        .instAck      (instAck),
        .renamed      (renamed),
        .renamedValid (renamedValid),
        .commitReq    (commitReq),
        .commitAck    (commitAck),
        .committed    (committed)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkRenamed(input RenamedOp got, input RenamedOp expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: renamed got %h expected %h", $time, got, expected);
            abortRun("Renamed op differs from the expected value");
        end
    endtask

    task automatic checkCommit(input CommitInfo got, input CommitInfo expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: committed got %h expected %h", $time, got, expected);
            abortRun("Commit record differs from the expected value");
        end
    endtask

    task automatic checkOrder(input int got, input int expected);
        if (got != expected) begin
            $display("Mismatch at %0t: commitsSeen got %0d expected %0d", $time, got, expected);
            abortRun("Renamed op left rename after the wrong number of commits");
        end
    endtask

    // Flags straight from the opcode rules
    function automatic OpInfo expectedInfo(input InstWord word);
        OpInfo info;
        logic [3:0] code;
        code = word[15:12];
        info = '0;
        info.dst = word[11:8];
        info.srcA = word[7:4];
        info.srcB = word[3:0];
        info.undefined = code > 4'd5;
        info.opcode = info.undefined ? OP_NOP : Opcode'(code);
        info.writeReg = (code == 4'd1) || (code == 4'd2);
        info.readA = (code >= 4'd1) && (code <= 4'd4);
        info.readB = (code == 4'd1) || (code == 4'd3) || (code == 4'd4);
        info.serialized = code == 4'd5;
        return info;
    endfunction

    task automatic readInstLine(input int fd, output InstWord word, output RenamedOp expected,
                                output int commitsBefore);
        int n;
        int wordVal;
        int srcA;
        int srcB;
        int dst;
        int prevDst;
        int ptr;
        n = $fscanf(fd, "%h %d %d %d %d %d %d", wordVal, srcA, srcB, dst, prevDst, ptr,
                    commitsBefore);
        if (n != 7) begin
            abortRun("Malformed instruction line in the test file");
        end
        word = InstWord'(wordVal);
        expected.info = expectedInfo(word);
        expected.phySrcA = PhyReg'(srcA);
        expected.phySrcB = PhyReg'(srcB);
        expected.phyDst = PhyReg'(dst);
        expected.phyPrevDst = PhyReg'(prevDst);
        expected.alPtr = AlPtr'(ptr);
    endtask

    task automatic readCommitLine(input int fd, output CommitInfo expected);
        int n;
        int dst;
        int phyDst;
        int prevDst;
        int writeReg;
        n = $fscanf(fd, "%d %d %d %d", dst, phyDst, prevDst, writeReg);
        if (n != 4) begin
            abortRun("Malformed commit line in the test file");
        end
        expected.dst = LogReg'(dst);
        expected.phyDst = PhyReg'(phyDst);
        expected.phyPrevDst = PhyReg'(prevDst);
        expected.writeReg = writeReg[0];
    endtask

    task automatic sendInst(input InstWord word);
        @(posedge clk);
        #DRIVE_DELAY;
        instWord = word;
        instReq = 1'b1;
        @(negedge clk);
        while (!instAck) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        instReq = 1'b0;
        @(negedge clk);
        while (instAck) @(negedge clk);
    endtask

    task automatic commitOne(input CommitInfo expected);
        @(posedge clk);
        #DRIVE_DELAY;
        commitReq = 1'b1;
        @(negedge clk);
        while (!commitAck) @(negedge clk);
        checkCommit(committed, expected);
        @(posedge clk);
        #DRIVE_DELAY;
        commitReq = 1'b0;
        @(negedge clk);
        while (commitAck) @(negedge clk);
        commitsIssued++;
    endtask

    // Counts retirements and checks each renamed op in program order
    always @(negedge clk) begin
        if (rst) begin
            commitsSeen = 0;
            prevCommitAck = 1'b0;
        end else begin
            if (commitAck && !prevCommitAck) begin
                commitsSeen++;
            end
            prevCommitAck = commitAck;
            if (renamedValid) begin
                if (expRenamed.size() == 0) begin
                    abortRun("Renamed op appeared while none was expected");
                end
                nextExp = expRenamed.pop_front();
                nextCount = expCommitsBefore.pop_front();
                checkRenamed(renamed, nextExp);
                checkOrder(commitsSeen, nextCount);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            abortRun($sformatf("Timeout: test did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        int        fd;
        int        n;
        int        lineCount;
        int        commitsBefore;
        string     kind;
        string     line;
        InstWord   word;
        RenamedOp  expInst;
        CommitInfo expCommit;

        rst = 1'b1;
        instReq = 1'b0;
        instWord = '0;
        commitReq = 1'b0;
        commitsIssued = 0;
        lineCount = 0;

        // First pass sizes the timeout
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abortRun("Cannot open the test file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                lineCount++;
            end
        end
        $fclose(fd);
        cycleLimit = CYCLES_PER_LINE * lineCount;
        fd = $fopen(TEST_FILE, "r");

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        while ($fscanf(fd, " %s", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(line, fd);
            end else if (kind == "I") begin
                readInstLine(fd, word, expInst, commitsBefore);
                expRenamed.push_back(expInst);
                expCommitsBefore.push_back(commitsBefore);
                sendInst(word);
            end else if (kind == "B") begin
                // Rename is stalled, so this handshake needs the next commit
                readInstLine(fd, word, expInst, commitsBefore);
                n = $fscanf(fd, " %s", kind);
                if (kind != "C") begin
                    abortRun("A blocked instruction line must be followed by a commit line");
                end
                readCommitLine(fd, expCommit);
                expRenamed.push_back(expInst);
                expCommitsBefore.push_back(commitsBefore);
                fork
                    sendInst(word);
                    begin
                        repeat (4) @(negedge clk);
                        if (instAck) begin
                            abortRun("Instruction accepted while rename was stalled");
                        end
                        commitOne(expCommit);
                    end
                join
            end else if (kind == "C") begin
                readCommitLine(fd, expCommit);
                commitOne(expCommit);
            end else begin
                abortRun($sformatf("Unknown line kind %s in the test file", kind));
            end
        end
        $fclose(fd);

        while (expRenamed.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        if (commitsSeen == commitsIssued) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abortRun("Commit count does not match the commit handshakes driven");
        end
    end

endmodule

`default_nettype wire

/* verification/renameTests.txt */
# I word srcA srcB dst prevDst alPtr commitsBefore (word in hex, the rest decimal)
# B is an I line blocked until the C line after it; C dst phyDst prevDst writeReg
I 1123 2 3 16 1 0 0
I 1214 16 4 17 2 1 0
I 3120 17 0 0 16 2 0
I 4210 16 0 0 17 3 0
C 1 16 1 1
C 2 17 2 1
C 1 0 16 0
C 2 0 17 0
I 1312 16 17 18 3 4 4
I 1433 18 18 19 4 5 4
I 1134 18 19 1 16 6 4
I 1211 1 1 2 17 7 4
I 1521 2 1 3 5 0 5
I 1652 3 2 4 6 1 6
B 4630 18 0 0 4 2 7
C 3 18 3 1
C 4 19 4 1
C 1 1 16 1
I 5700 0 0 0 7 3 11
I 1713 1 18 16 7 4 12
C 2 2 17 1
C 5 3 5 1
C 6 4 6 1
C 6 0 4 0
C 7 0 7 0
C 7 16 7 1
I 0123 0 0 0 1 5 13
C 1 0 1 0

/* sim.f */
source/RenameTypes.sv
source/OpDecoder.sv
source/RenameSerializer.sv
source/RenameStage.sv
source/RenameMapTable.sv
source/ActiveList.sv
source/RenameCore.sv
verification/RenameCoreTb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - files:
      - source/RenameTypes.sv
      - source/OpDecoder.sv
      - source/RenameSerializer.sv
      - source/RenameStage.sv
      - source/RenameMapTable.sv
      - source/ActiveList.sv
      - source/RenameCore.sv
  - target: test
    files:
      - verification/RenameCoreTb.sv
